// ==== files.f ====
hw/rv32_pkg.sv
hw/alu.sv
hw/fetch_unit.sv
hw/decode_unit.sv
hw/register_file.sv
hw/execute_unit.sv
hw/rv32i_core.sv
verification/rv32i_core_props.sv
verification/rv32i_core_tb.sv

// ==== hw/alu.sv ====
// RV32I integer ALU
// Add, subtract, logic, shifts, set-less-than and pass-B
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  rv32_pkg::alu_op_t alu_op,
    input  rv32_pkg::xlen_t   a,
    input  rv32_pkg::xlen_t   b,
    output rv32_pkg::xlen_t   result
);

    import rv32_pkg::*;

    logic [4:0] shamt;

    // Shift amount from the low five bits only
    assign shamt = b[4:0];

    always_comb begin
        case (alu_op)
            ALU_ADD:    result = a + b;
            ALU_SUB:    result = a - b;
            ALU_AND:    result = a & b;
            ALU_OR:     result = a | b;
            ALU_XOR:    result = a ^ b;
            ALU_SLL:    result = a << shamt;
            ALU_SRL:    result = a >> shamt;
            // Arithmetic shift keeps the sign
            ALU_SRA:    result = xlen_t'($signed(a) >>> shamt);
            ALU_SLT:    result = {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU:   result = {31'b0, a < b};
            ALU_PASS_B: result = b;
            default:    result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/decode_unit.sv ====
// Decode stage
// Field split, immediates, control bits and the ID/EX register
`timescale 1ns/1ns
`default_nettype none

module decode_unit (
    input  logic                clk,
    input  logic                rst,
    input  logic                if_valid,
    input  rv32_pkg::xlen_t     if_pc,
    input  rv32_pkg::instr_t    if_instr,
    input  rv32_pkg::redirect_t redirect,
    output rv32_pkg::reg_addr_t rs1_addr,
    output rv32_pkg::reg_addr_t rs2_addr,
    input  rv32_pkg::xlen_t     rs1_data,
    input  rv32_pkg::xlen_t     rs2_data,
    output rv32_pkg::id_ex_t    id_ex
);

    import rv32_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t  rd;
    xlen_t      imm_i;
    xlen_t      imm_u;
    xlen_t      imm_b;
    xlen_t      imm_j;
    id_ex_t     id_ex_d;

    // --------------------------------------------------
    // Fields and immediates
    // --------------------------------------------------
    assign opcode   = if_instr[6:0];
    assign rd       = if_instr[11:7];
    assign funct3   = if_instr[14:12];
    assign rs1_addr = if_instr[19:15];
    assign rs2_addr = if_instr[24:20];
    assign funct7   = if_instr[31:25];

    assign imm_i = {{20{if_instr[31]}}, if_instr[31:20]};
    assign imm_u = {if_instr[31:12], 12'b0};
    // Branch offset, bit 0 always zero
    assign imm_b = {{19{if_instr[31]}}, if_instr[31], if_instr[7],
                    if_instr[30:25], if_instr[11:8], 1'b0};
    assign imm_j = {{11{if_instr[31]}}, if_instr[31], if_instr[19:12],
                    if_instr[20], if_instr[30:21], 1'b0};

    // funct3 to ALU op, alt is funct7[5]
    // SUB exists only in the register form
    function automatic alu_op_t alu_decode(input logic [2:0] f3, input logic alt,
                                           input logic is_reg);
        alu_op_t op;
        case (f3)
            3'b000:  op = (alt && is_reg) ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    // --------------------------------------------------
    // Control generation
    // --------------------------------------------------
    always_comb begin
        id_ex_d           = '0;
        id_ex_d.valid     = if_valid;
        id_ex_d.pc        = if_pc;
        id_ex_d.rs1       = rs1_addr;
        id_ex_d.rs2       = rs2_addr;
        id_ex_d.rs1_data  = rs1_data;
        id_ex_d.rs2_data  = rs2_data;
        id_ex_d.rd        = rd;
        id_ex_d.funct3    = funct3;
        id_ex_d.imm       = imm_i;
        id_ex_d.alu_op    = ALU_ADD;
        case (opcode)
            OPC_OP: begin
                id_ex_d.reg_write = 1'b1;
                id_ex_d.alu_op    = alu_decode(funct3, funct7[5], 1'b1);
            end
            OPC_OP_IMM: begin
                id_ex_d.reg_write = 1'b1;
                id_ex_d.use_imm   = 1'b1;
                id_ex_d.alu_op    = alu_decode(funct3, funct7[5], 1'b0);
            end
            OPC_LUI: begin
                id_ex_d.reg_write = 1'b1;
                id_ex_d.use_imm   = 1'b1;
                id_ex_d.imm       = imm_u;
                id_ex_d.alu_op    = ALU_PASS_B;
            end
            OPC_AUIPC: begin
                id_ex_d.reg_write = 1'b1;
                id_ex_d.use_imm   = 1'b1;
                id_ex_d.use_pc    = 1'b1;
                id_ex_d.imm       = imm_u;
            end
            OPC_BRANCH: begin
                id_ex_d.is_branch = 1'b1;
                id_ex_d.imm       = imm_b;
            end
            OPC_JAL: begin
                id_ex_d.reg_write = 1'b1;
                id_ex_d.is_jal    = 1'b1;
                id_ex_d.imm       = imm_j;
            end
            OPC_JALR: begin
                id_ex_d.reg_write = 1'b1;
                id_ex_d.is_jalr   = 1'b1;
            end
            // Unknown opcode, no register write
            default: ;
        endcase
    end

    // ID/EX register, younger slot killed on redirect
    always_ff @(posedge clk) begin
        id_ex <= id_ex_d;
        if (rst || redirect.valid) begin
            id_ex.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== hw/execute_unit.sv ====
// Execute stage
// Forwarding, ALU, branch and jump resolution, EX/WB register
`timescale 1ns/1ns
`default_nettype none

module execute_unit (
    input  logic                clk,
    input  logic                rst,
    input  rv32_pkg::id_ex_t    id_ex,
    output rv32_pkg::redirect_t redirect,
    output rv32_pkg::wb_t       wb
);

    import rv32_pkg::*;

    logic  fwd_rs1;
    logic  fwd_rs2;
    logic  cond;
    logic  take;
    logic  is_jump;
    xlen_t op_rs1;
    xlen_t op_rs2;
    xlen_t alu_a;
    xlen_t alu_b;
    xlen_t alu_result;
    xlen_t pc_plus4;
    xlen_t target;
    xlen_t result;

    // --------------------------------------------------
    // Operand forwarding from EX/WB
    // --------------------------------------------------
    assign fwd_rs1 = wb.valid && wb.rd != '0 && wb.rd == id_ex.rs1;
    assign fwd_rs2 = wb.valid && wb.rd != '0 && wb.rd == id_ex.rs2;

    assign op_rs1 = fwd_rs1 ? wb.data : id_ex.rs1_data;
    assign op_rs2 = fwd_rs2 ? wb.data : id_ex.rs2_data;

    // pc as A for AUIPC, immediate as B for I-type and upper forms
    assign alu_a = id_ex.use_pc ? id_ex.pc : op_rs1;
    assign alu_b = id_ex.use_imm ? id_ex.imm : op_rs2;

    alu u_alu (
        .alu_op (id_ex.alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result)
    );

    // --------------------------------------------------
    // Branch and jump resolution
    // --------------------------------------------------
    always_comb begin
        case (id_ex.funct3)
            3'b000:  cond = op_rs1 == op_rs2;
            3'b001:  cond = op_rs1 != op_rs2;
            3'b100:  cond = $signed(op_rs1) < $signed(op_rs2);
            3'b101:  cond = $signed(op_rs1) >= $signed(op_rs2);
            3'b110:  cond = op_rs1 < op_rs2;
            3'b111:  cond = op_rs1 >= op_rs2;
            // Reserved encodings never taken
            default: cond = 1'b0;
        endcase
    end

    assign is_jump = id_ex.is_jal || id_ex.is_jalr;
    assign take    = id_ex.valid && ((id_ex.is_branch && cond) || is_jump);

    // JALR target has bit 0 cleared
    assign target = id_ex.is_jalr ? ((op_rs1 + id_ex.imm) & ~32'd1)
                                  : (id_ex.pc + id_ex.imm);

    assign redirect.valid  = take;
    assign redirect.target = target;

    // Link value for jumps
    assign pc_plus4 = id_ex.pc + 32'd4;
    assign result   = is_jump ? pc_plus4 : alu_result;

    // --------------------------------------------------
    // EX/WB register
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= id_ex.valid && id_ex.reg_write && id_ex.rd != '0;
        end
        wb.rd   <= id_ex.rd;
        wb.data <= result;
    end

endmodule

`default_nettype wire

// ==== hw/fetch_unit.sv ====
// Fetch stage
// Program counter, not-taken prediction, IF/ID register
`timescale 1ns/1ns
`default_nettype none

module fetch_unit #(
    parameter rv32_pkg::xlen_t RESET_PC = '0
) (
    input  logic                clk,
    input  logic                rst,
    output rv32_pkg::xlen_t     imem_addr,
    input  rv32_pkg::instr_t    imem_data,
    input  rv32_pkg::redirect_t redirect,
    output logic                if_valid,
    output rv32_pkg::xlen_t     if_pc,
    output rv32_pkg::instr_t    if_instr
);

    import rv32_pkg::*;

    xlen_t pc;

    // Next pc is pc+4 unless execute resolves a taken branch or a jump
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if (redirect.valid) begin
            pc <= redirect.target;
        end else begin
            pc <= pc + 32'd4;
        end
    end

    // Memory read is combinational in the same cycle
    assign imem_addr = pc;

    // --------------------------------------------------
    // IF/ID register
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if_pc <= pc;
        // Slot fetched under a redirect becomes a bubble
        if (rst || redirect.valid) begin
            if_valid <= 1'b0;
            if_instr <= NOP_INSTR;
        end else begin
            if_valid <= 1'b1;
            if_instr <= imem_data;
        end
    end

endmodule

`default_nettype wire

// ==== hw/register_file.sv ====
// Integer register file, 32 x 32
// x0 reads zero, writes bypass to the read ports
`timescale 1ns/1ns
`default_nettype none

module register_file (
    input  logic                clk,
    input  logic                rst,
    input  rv32_pkg::reg_addr_t rs1_addr,
    input  rv32_pkg::reg_addr_t rs2_addr,
    output rv32_pkg::xlen_t     rs1_data,
    output rv32_pkg::xlen_t     rs2_data,
    input  rv32_pkg::wb_t       wb
);

    import rv32_pkg::*;

    // No storage for x0
    xlen_t regs [1:31];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && wb.rd != '0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // Same-cycle write wins over the stored value
    function automatic xlen_t read_port(input reg_addr_t addr);
        xlen_t value;
        if (addr == '0) begin
            value = '0;
        end else if (wb.valid && wb.rd == addr) begin
            value = wb.data;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_comb begin
        rs1_data = read_port(rs1_addr);
        rs2_data = read_port(rs2_addr);
    end

endmodule

`default_nettype wire

// ==== hw/rv32_pkg.sv ====
// RV32I core shared definitions
// Word widths, opcode and ALU codes, pipeline register layouts
`default_nettype none

package rv32_pkg;

    // --------------------------------------------------
    // Basic widths
    // --------------------------------------------------
    typedef logic [31:0] xlen_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  alu_op_t;

    // Major opcodes, instr[6:0]
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    // ALU operation codes
    localparam alu_op_t ALU_ADD    = 4'd0;
    localparam alu_op_t ALU_SUB    = 4'd1;
    localparam alu_op_t ALU_AND    = 4'd2;
    localparam alu_op_t ALU_OR     = 4'd3;
    localparam alu_op_t ALU_XOR    = 4'd4;
    localparam alu_op_t ALU_SLL    = 4'd5;
    localparam alu_op_t ALU_SRL    = 4'd6;
    localparam alu_op_t ALU_SRA    = 4'd7;
    localparam alu_op_t ALU_SLT    = 4'd8;
    localparam alu_op_t ALU_SLTU   = 4'd9;
    // Operand B straight through, used by LUI
    localparam alu_op_t ALU_PASS_B = 4'd10;

    // ADDI x0, x0, 0
    localparam instr_t NOP_INSTR = 32'h0000_0013;

    // --------------------------------------------------
    // Pipeline registers
    // --------------------------------------------------
    // Decoded instruction held in ID/EX
    typedef struct packed {
        logic      valid;
        xlen_t     pc;
        reg_addr_t rs1;
        reg_addr_t rs2;
        xlen_t     rs1_data;
        xlen_t     rs2_data;
        xlen_t     imm;
        reg_addr_t rd;
        logic      reg_write;
        alu_op_t   alu_op;
        // Operand B from immediate
        logic      use_imm;
        // Operand A from pc, AUIPC only
        logic      use_pc;
        logic      is_branch;
        logic      is_jal;
        logic      is_jalr;
        // Branch condition select
        logic [2:0] funct3;
    } id_ex_t;

    // Retiring result into the register file
    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        xlen_t     data;
    } wb_t;

    // Redirect from execute back to fetch
    typedef struct packed {
        logic  valid;
        xlen_t target;
    } redirect_t;

endpackage

`default_nettype wire

// ==== hw/rv32i_core.sv ====
// RV32I core top level
// Four stages with branch redirect resolved in execute
`timescale 1ns/1ns
`default_nettype none

module rv32i_core #(
    parameter rv32_pkg::xlen_t RESET_PC = '0
) (
    input  logic             clk,
    input  logic             rst,
    output rv32_pkg::xlen_t  imem_addr,
    input  rv32_pkg::instr_t imem_data,
    output rv32_pkg::wb_t    wb
);

    import rv32_pkg::*;

    // IF/ID
    logic      if_valid;
    xlen_t     if_pc;
    instr_t    if_instr;

    // Register file read ports
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    xlen_t     rs1_data;
    xlen_t     rs2_data;

    // ID/EX and the execute feedback
    id_ex_t    id_ex;
    redirect_t redirect;

    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk       (clk),
        .rst       (rst),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .redirect  (redirect),
        .if_valid  (if_valid),
        .if_pc     (if_pc),
        .if_instr  (if_instr)
    );

    decode_unit u_decode (
        .clk      (clk),
        .rst      (rst),
        .if_valid (if_valid),
        .if_pc    (if_pc),
        .if_instr (if_instr),
        .redirect (redirect),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .id_ex    (id_ex)
    );

    // Write port is driven by EX/WB directly
    register_file u_regfile (
        .clk      (clk),
        .rst      (rst),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb       (wb)
    );

    execute_unit u_execute (
        .clk      (clk),
        .rst      (rst),
        .id_ex    (id_ex),
        .redirect (redirect),
        .wb       (wb)
    );

endmodule

`default_nettype wire

// ==== verification/rv32i_core_props.sv ====
// RV32I core protocol checks
// Redirect landing, squashed writeback and fetch alignment
`timescale 1ns/1ns
`default_nettype none

module rv32i_core_props (
    input logic                clk,
    input logic                rst,
    input rv32_pkg::xlen_t     imem_addr,
    input rv32_pkg::wb_t       wb,
    input rv32_pkg::redirect_t redirect
);

    import rv32_pkg::*;

    // Assertion failures so far
    int failures = 0;

    // Fetch lands on the target one cycle after the pulse
    redirect_lands: assert property (@(posedge clk) disable iff (rst)
        redirect.valid |=> imem_addr == $past(redirect.target))
        else begin
            $error("fetch address differs from the redirect target");
            failures++;
        end

    // Both slots squashed behind a redirect retire nothing
    squash_no_wb: assert property (@(posedge clk) disable iff (rst)
        ($past(redirect.valid, 2) || $past(redirect.valid, 3)) |-> !wb.valid)
        else begin
            $error("wb from a slot squashed by a redirect");
            failures++;
        end

    fetch_aligned: assert property (@(posedge clk) disable iff (rst)
        imem_addr[1:0] == 2'b00)
        else begin
            $error("fetch address not word aligned");
            failures++;
        end

endmodule

bind rv32i_core rv32i_core_props u_props (
    .clk       (clk),
    .rst       (rst),
    .imem_addr (imem_addr),
    .wb        (wb),
    .redirect  (redirect)
);

`default_nettype wire

// ==== verification/rv32i_core_tb.sv ====
// RV32I core testbench
// Directed tests against an instruction memory model, with in-order wb checks
`timescale 1ns/1ns
`default_nettype none

module rv32i_core_tb;

    import rv32_pkg::*;

    localparam int RESET_CYCLES   = 4;
    localparam int RUN_CYCLES     = 100;
    localparam int NUM_TESTS      = 5;
    // Reset, collection window and two edges of slack per test
    localparam int TIMEOUT_CYCLES = NUM_TESTS * (RESET_CYCLES + RUN_CYCLES + 2) + 70;
    // JAL x0, 0 spins in place
    localparam instr_t HALT = 32'h0000_006f;

    logic        clk;
    logic        rst;
    xlen_t       imem_addr;
    instr_t      imem_data;
    wb_t         wb;

    instr_t      imem [0:63];
    int          wr_ptr;
    // Architectural register values as the program should leave them
    xlen_t       shadow [0:31];
    wb_t         exp_q [$];
    wb_t         got_q [$];
    logic [15:0] lfsr_state;
    int          cycle_count = 0;
    int          checks;
    int          errors;

    rv32i_core DUT (
        .clk       (clk),
        .rst       (rst),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .wb        (wb)
    );

    // Combinational instruction read, word index
    assign imem_data = imem[imem_addr[7:2]];

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) cycle_count <= cycle_count + 1;

    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

    // --------------------------------------------------
    // Random bits, x^16 + x^14 + x^13 + x^11 + 1
    // --------------------------------------------------
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic xlen_t rand_word(input int nbits);
        xlen_t value;
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            value = {value[30:0], lfsr_step()};
        end
        return value;
    endfunction

    // --------------------------------------------------
    // Instruction encoders
    // --------------------------------------------------
    function automatic instr_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                     input reg_addr_t rs1, input logic [2:0] f3,
                                     input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic instr_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                     input logic [2:0] f3, input reg_addr_t rd,
                                     input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic instr_t enc_u(input logic [19:0] imm, input reg_addr_t rd,
                                     input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    // Offsets in bytes, bit 0 dropped by the format
    function automatic instr_t enc_b(input logic [12:0] off, input reg_addr_t rs2,
                                     input reg_addr_t rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic instr_t enc_j(input logic [20:0] off, input reg_addr_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    // Branch condition per funct3
    function automatic logic branch_taken(input logic [2:0] f3, input xlen_t a,
                                          input xlen_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // BEQ, BNE, BLT, BGE, BLTU, BGEU in turn
    function automatic logic [2:0] branch_code(input int idx);
        case (idx)
            0:       return 3'b000;
            1:       return 3'b001;
            2:       return 3'b100;
            3:       return 3'b101;
            4:       return 3'b110;
            default: return 3'b111;
        endcase
    endfunction

    // --------------------------------------------------
    // Program building
    // --------------------------------------------------
    task clear_program();
        for (int i = 0; i < 64; i++) begin
            imem[i] = HALT;
        end
        for (int i = 0; i < 32; i++) begin
            shadow[i] = '0;
        end
        wr_ptr = 0;
        exp_q.delete();
        got_q.delete();
    endtask

    function automatic xlen_t cur_pc();
        xlen_t pc;
        pc = wr_ptr;
        return pc << 2;
    endfunction

    task emit(input instr_t ins);
        imem[wr_ptr] = ins;
        wr_ptr = wr_ptr + 1;
    endtask

    task expect_write(input reg_addr_t rd, input xlen_t data);
        wb_t ev;
        // x0 stays zero and retires without a write
        if (rd != 5'd0) begin
            ev.valid = 1'b1;
            ev.rd    = rd;
            ev.data  = data;
            exp_q.push_back(ev);
            shadow[rd] = data;
        end
    endtask

    // Write that must never retire
    task emit_marker(input reg_addr_t rd, input logic [11:0] imm);
        emit(enc_i(imm, 5'd0, 3'b000, rd, OPC_OP_IMM));
    endtask

    task pad_to(input xlen_t addr);
        while (cur_pc() < addr) begin
            emit_marker(5'd31, 12'h7ff);
        end
    endtask

    task emit_addi(input reg_addr_t rd, input reg_addr_t rs1, input logic [11:0] imm);
        expect_write(rd, shadow[rs1] + {{20{imm[11]}}, imm});
        emit(enc_i(imm, rs1, 3'b000, rd, OPC_OP_IMM));
    endtask

    task emit_add(input reg_addr_t rd, input reg_addr_t rs1, input reg_addr_t rs2);
        expect_write(rd, shadow[rs1] + shadow[rs2]);
        emit(enc_r(7'h00, rs2, rs1, 3'b000, rd));
    endtask

    task emit_auipc(input reg_addr_t rd, input logic [19:0] imm);
        expect_write(rd, cur_pc() + {imm, 12'b0});
        emit(enc_u(imm, rd, OPC_AUIPC));
    endtask

    // LUI then ADDI, upper part rounded for the signed low half
    task load_const(input reg_addr_t rd, input xlen_t value);
        xlen_t      rounded;
        logic [19:0] hi;
        rounded = value + 32'h800;
        hi      = rounded[31:12];
        expect_write(rd, {hi, 12'b0});
        emit(enc_u(hi, rd, OPC_LUI));
        emit_addi(rd, rd, value[11:0]);
    endtask

    // R-type on x1, x2 and I-type on x1
    task alu_r(input logic [2:0] f3, input logic [6:0] f7, input reg_addr_t rd,
               input xlen_t value);
        expect_write(rd, value);
        emit(enc_r(f7, 5'd2, 5'd1, f3, rd));
    endtask

    task alu_i(input logic [2:0] f3, input logic [11:0] imm, input reg_addr_t rd,
               input xlen_t value);
        expect_write(rd, value);
        emit(enc_i(imm, 5'd1, f3, rd, OPC_OP_IMM));
    endtask

    // --------------------------------------------------
    // Running and checking
    // --------------------------------------------------
    task reset_dut();
        @(negedge clk);
        rst = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
    endtask

    task compare_events(input string name);
        wb_t e;
        wb_t g;
        for (int i = 0; i < exp_q.size(); i++) begin
            checks = checks + 1;
            e = exp_q[i];
            if (i >= got_q.size()) begin
                errors = errors + 1;
                $display("%s: no wb event came for the write of %h to x%0d",
                         name, e.data, e.rd);
            end else begin
                g = got_q[i];
                if (g.rd != e.rd || g.data != e.data) begin
                    errors = errors + 1;
                    $display("mismatch %s event %0d: expected x%0d=%h, actual x%0d=%h",
                             name, i, e.rd, e.data, g.rd, g.data);
                end
            end
        end
        for (int i = exp_q.size(); i < got_q.size(); i++) begin
            errors = errors + 1;
            g = got_q[i];
            $display("%s: unexpected extra wb event writing %h to x%0d", name, g.data, g.rd);
        end
    endtask

    // Outputs settle after the rising edge, sampled on the falling one
    task run_program(input string name);
        reset_dut();
        repeat (RUN_CYCLES) begin
            @(negedge clk);
            if (wb.valid) begin
                got_q.push_back(wb);
            end
        end
        compare_events(name);
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------
    task test_alu();
        xlen_t       a;
        xlen_t       b;
        xlen_t       r;
        xlen_t       immx;
        logic [11:0] imm;
        logic [4:0]  sh;
        clear_program();
        a    = rand_word(32);
        b    = rand_word(32);
        r    = rand_word(12);
        imm  = r[11:0];
        r    = rand_word(5);
        sh   = r[4:0];
        immx = {{20{imm[11]}}, imm};
        load_const(5'd1, a);
        load_const(5'd2, b);
        alu_r(3'b000, 7'h00, 5'd3, a + b);
        alu_r(3'b000, 7'h20, 5'd4, a - b);
        alu_r(3'b111, 7'h00, 5'd5, a & b);
        alu_r(3'b110, 7'h00, 5'd6, a | b);
        alu_r(3'b100, 7'h00, 5'd7, a ^ b);
        alu_r(3'b001, 7'h00, 5'd8, a << b[4:0]);
        alu_r(3'b101, 7'h00, 5'd9, a >> b[4:0]);
        r = $signed(a) >>> b[4:0];
        alu_r(3'b101, 7'h20, 5'd10, r);
        alu_r(3'b010, 7'h00, 5'd11, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
        alu_r(3'b011, 7'h00, 5'd12, (a < b) ? 32'd1 : 32'd0);
        // Immediate forms
        alu_i(3'b000, imm, 5'd13, a + immx);
        alu_i(3'b111, imm, 5'd14, a & immx);
        alu_i(3'b110, imm, 5'd15, a | immx);
        alu_i(3'b100, imm, 5'd16, a ^ immx);
        alu_i(3'b010, imm, 5'd17, ($signed(a) < $signed(immx)) ? 32'd1 : 32'd0);
        alu_i(3'b011, imm, 5'd18, (a < immx) ? 32'd1 : 32'd0);
        alu_i(3'b001, {7'h00, sh}, 5'd19, a << sh);
        alu_i(3'b101, {7'h00, sh}, 5'd20, a >> sh);
        r = $signed(a) >>> sh;
        alu_i(3'b101, {7'h20, sh}, 5'd21, r);
        run_program("alu");
    endtask

    // Distance 1 hits EX/WB, distance 2 the register file bypass
    task test_forwarding();
        clear_program();
        load_const(5'd1, rand_word(32));
        emit_add(5'd2, 5'd1, 5'd1);
        emit_add(5'd3, 5'd1, 5'd2);
        emit_add(5'd4, 5'd3, 5'd2);
        emit_add(5'd5, 5'd4, 5'd3);
        emit_add(5'd6, 5'd5, 5'd4);
        emit_add(5'd7, 5'd6, 5'd6);
        emit_add(5'd8, 5'd5, 5'd7);
        run_program("forwarding");
    endtask

    // Each branch skips two markers to land on a tag write
    task test_branches();
        logic [2:0] f3;
        reg_addr_t  s1;
        reg_addr_t  s2;
        logic       odd;
        clear_program();
        emit_addi(5'd1, 5'd0, 12'hffb);
        emit_addi(5'd2, 5'd0, 12'd3);
        for (int k = 0; k < 12; k++) begin
            f3  = branch_code(k / 2);
            odd = (k % 2) == 1;
            // Equality compares x1 with itself, ordering swaps the pair
            if (!f3[2]) begin
                s1 = 5'd1;
                s2 = odd ? 5'd2 : 5'd1;
            end else begin
                s1 = odd ? 5'd2 : 5'd1;
                s2 = odd ? 5'd1 : 5'd2;
            end
            emit(enc_b(13'd12, s2, s1, f3));
            if (branch_taken(f3, shadow[s1], shadow[s2])) begin
                emit_marker(5'd10, 12'(100 + k));
                emit_marker(5'd11, 12'(200 + k));
            end else begin
                emit_addi(5'd10, 5'd0, 12'(100 + k));
                emit_addi(5'd11, 5'd0, 12'(200 + k));
            end
            emit_addi(5'd12, 5'd0, 12'(k));
        end
        run_program("branches");
    endtask

    task test_jumps();
        xlen_t jal_pc;
        clear_program();
        jal_pc = cur_pc();
        expect_write(5'd1, jal_pc + 32'd4);
        emit(enc_j(21'd16, 5'd1));
        pad_to(jal_pc + 32'd16);
        emit_addi(5'd2, 5'd0, 12'd40);
        expect_write(5'd3, cur_pc() + 32'd4);
        emit(enc_i(12'd4, 5'd2, 3'b000, 5'd3, OPC_JALR));
        pad_to((shadow[2] + 32'd4) & ~32'd1);
        // Link value read back
        emit_addi(5'd4, 5'd1, 12'd0);
        // Odd sum, bit 0 cleared
        expect_write(5'd5, cur_pc() + 32'd4);
        emit(enc_i(12'd21, 5'd2, 3'b000, 5'd5, OPC_JALR));
        pad_to((shadow[2] + 32'd21) & ~32'd1);
        emit_addi(5'd6, 5'd5, 12'd0);
        run_program("jumps");
    endtask

    task test_auipc_x0();
        xlen_t r;
        clear_program();
        emit_addi(5'd0, 5'd0, 12'd123);
        r = rand_word(20);
        emit_auipc(5'd1, r[19:0]);
        emit_add(5'd0, 5'd1, 5'd1);
        // x0 read right behind a write to it
        emit_add(5'd2, 5'd0, 5'd1);
        emit_addi(5'd3, 5'd0, 12'd7);
        emit_auipc(5'd4, 20'h00000);
        emit_add(5'd5, 5'd0, 5'd0);
        run_program("auipc_x0");
    endtask

    initial begin
        rst        = 1'b1;
        lfsr_state = 16'd67;
        checks     = 0;
        errors     = 0;
        clear_program();
        test_alu();
        test_forwarding();
        test_branches();
        test_jumps();
        test_auipc_x0();
        errors = errors + DUT.u_props.failures;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
